//--- all.f
cfg_net_pkg.sv
cfg_frame_rx.sv
cfg_node.sv
cfg_net_top.sv
cfg_node_probe.sv
tb_cfg_net.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_cfg_net -o sim_cfg_net

out=$(./obj_dir/sim_cfg_net)
echo "$out"

if echo "$out" | grep -qF '*** PASSED ***'; then
  exit 0
fi
exit 1

//--- cfg_testdata.txt
# test (decimal)  id  data  bad_parity  gaps   (id, data and flags in hex)
# bad_parity inverts the parity bit, gaps pauses cfg_en at random inside the frame
1 11 1234 0 0
2 22 beef 0 0
3 33 cafe 0 0
4 ff 5a5a 0 0
5 11 0f0f 1 0
6 44 ffff 0 0
7 22 00a7 0 0
8 22 0000 0 0
9 22 00a7 0 1
10 ff 9876 0 1
11 33 0003 1 1
12 00 1111 0 0
13 33 0007 0 0
14 11 a5c3 0 1
15 ff 0000 0 0
16 11 ffff 1 0
17 33 fff1 0 1
18 fe 4321 0 1
19 22 1234 1 1
20 ff c3a5 0 0

//--- tb_cfg_net.sv
module tb_cfg_net;

  localparam int half_period   = 2;
  localparam int reset_cycles  = 10;
  localparam int idle_cycles   = 12;  // quiet line after each frame
  localparam int max_gap       = 3;   // longest cfg_en pause before one bit
  localparam int margin_cycles = 200;

  logic                                clk;
  logic                                rst_n;
  logic                                cfg_en;
  logic                                cfg_bit;
  logic [cfg_net_pkg::node0_bits-1:0]  node0_data;
  logic [cfg_net_pkg::node1_bits-1:0]  node1_data;
  logic [cfg_net_pkg::node2_bits-1:0]  node2_data;
  cfg_net_pkg::err_count_t             err_count;

  // reference model
  logic [cfg_net_pkg::node0_bits-1:0]  exp0;
  logic [cfg_net_pkg::node1_bits-1:0]  exp1;
  logic [cfg_net_pkg::node2_bits-1:0]  exp2;
  cfg_net_pkg::err_count_t             exp_err;
  int                                  exp_chg [3];

  int chg0, chg1, chg2;  // probe change counts
  int mis0, mis1, mis2;  // probe mismatch counts

  // one entry per line of the data file
  int                     tnum_q [$];
  cfg_net_pkg::node_id_t  id_q [$];
  cfg_net_pkg::cfg_data_t data_q [$];
  logic                   bad_q [$];
  logic                   gap_q [$];

  int   cur_test;
  int   test_errs;
  int   pass_count;
  int   fail_count;
  int   watchdog_cycles;
  logic watchdog_armed;

  cfg_net_top DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg_en     (cfg_en),
    .cfg_bit    (cfg_bit),
    .node0_data (node0_data),
    .node1_data (node1_data),
    .node2_data (node2_data),
    .err_count  (err_count)
  );

  cfg_node_probe #(.node_num(0), .width(cfg_net_pkg::node0_bits)) probe0 (
    .clk(clk), .rst_n(rst_n), .data(node0_data), .expected(exp0),
    .change_count(chg0), .mismatch_count(mis0)
  );
  cfg_node_probe #(.node_num(1), .width(cfg_net_pkg::node1_bits)) probe1 (
    .clk(clk), .rst_n(rst_n), .data(node1_data), .expected(exp1),
    .change_count(chg1), .mismatch_count(mis1)
  );
  cfg_node_probe #(.node_num(2), .width(cfg_net_pkg::node2_bits)) probe2 (
    .clk(clk), .rst_n(rst_n), .data(node2_data), .expected(exp2),
    .change_count(chg2), .mismatch_count(mis2)
  );

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // limit assumes every frame is fully gapped
  initial begin
    wait (watchdog_armed === 1'b1);
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: the run hung, no result after %0d cycles", watchdog_cycles);
    $display("*** FAILED ***");
    $finish;
  end

  // data file columns are test number (decimal), id, data, bad parity flag and gap flag
  task automatic load_tests();
    int                     fd;
    int                     code;
    int                     ch;
    int                     num;
    cfg_net_pkg::node_id_t  id;
    cfg_net_pkg::cfg_data_t d;
    logic                   bad;
    logic                   gap;
    fd = $fopen("cfg_testdata.txt", "r");
    if (fd == 0) begin
      $display("error: cannot open cfg_testdata.txt");
      fail_count++;
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, "%d %h %h %h %h\n", num, id, d, bad, gap);
        if (code == 5) begin
          tnum_q.push_back(num);
          id_q.push_back(id);
          data_q.push_back(d);
          bad_q.push_back(bad);
          gap_q.push_back(gap);
        end else begin
          ch = $fgetc(fd); // skip the rest of a comment line
          while (ch != 10 && ch != -1) begin
            ch = $fgetc(fd);
          end
        end
      end
      $fclose(fd);
    end
    if (tnum_q.size() == 0) begin
      $display("error: no test lines found in cfg_testdata.txt");
      fail_count++;
    end
  endtask

  // sometimes pause cfg_en for a few cycles and toggle the line meanwhile
  task automatic insert_gap();
    int len;
    if ($urandom_range(3, 0) == 0) begin
      len = $urandom_range(max_gap, 1);
      repeat (len) begin
        @(negedge clk);
        cfg_en  = 1'b0;
        cfg_bit = ~cfg_bit; // ignored while paused
      end
    end
  endtask

  task automatic send_frame(input cfg_net_pkg::node_id_t id, input cfg_net_pkg::cfg_data_t d,
                            input logic bad, input logic gaps);
    logic [cfg_net_pkg::frame_bits-1:0] frame;
    logic                               par;
    int                                 i;
    par   = ^{id, d}; // even parity over id and data
    frame = {1'b1, id, d, par ^ bad};
    for (i = cfg_net_pkg::frame_bits - 1; i >= 0; i--) begin
      if (gaps) insert_gap();
      @(negedge clk);
      cfg_en  = 1'b1;
      cfg_bit = frame[i];
    end
    @(negedge clk);
    cfg_bit = 1'b0;
    repeat (idle_cycles) @(negedge clk);
  endtask

  task automatic update_model(input cfg_net_pkg::node_id_t id, input cfg_net_pkg::cfg_data_t d,
                              input logic bad);
    if (bad) begin
      exp_err = exp_err + 8'd1; // wraps modulo 256
    end else begin
      if ((id == cfg_net_pkg::node0_id || id == cfg_net_pkg::broadcast_id) &&
          exp0 != d[cfg_net_pkg::node0_bits-1:0]) begin
        exp0 = d[cfg_net_pkg::node0_bits-1:0];
        exp_chg[0]++;
      end
      if ((id == cfg_net_pkg::node1_id || id == cfg_net_pkg::broadcast_id) &&
          exp1 != d[cfg_net_pkg::node1_bits-1:0]) begin
        exp1 = d[cfg_net_pkg::node1_bits-1:0];
        exp_chg[1]++;
      end
      if ((id == cfg_net_pkg::node2_id || id == cfg_net_pkg::broadcast_id) &&
          exp2 != d[cfg_net_pkg::node2_bits-1:0]) begin
        exp2 = d[cfg_net_pkg::node2_bits-1:0];
        exp_chg[2]++;
      end
    end
  endtask

  task automatic check_value(input string what, input cfg_net_pkg::cfg_data_t got,
                             input cfg_net_pkg::cfg_data_t exp);
    assert (got === exp) else begin
      $display("[FAIL] t=%0t test %0d: %s is %h, expected %h",
               $time, cur_test, what, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    assert (got == exp) else begin
      $display("[FAIL] t=%0t test %0d: %s is %0d, expected %0d",
               $time, cur_test, what, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_state();
    check_value("node0_data", cfg_net_pkg::cfg_data_t'(node0_data),
                cfg_net_pkg::cfg_data_t'(exp0));
    check_value("node1_data", cfg_net_pkg::cfg_data_t'(node1_data),
                cfg_net_pkg::cfg_data_t'(exp1));
    check_value("node2_data", cfg_net_pkg::cfg_data_t'(node2_data),
                cfg_net_pkg::cfg_data_t'(exp2));
    check_value("err_count", cfg_net_pkg::cfg_data_t'(err_count),
                cfg_net_pkg::cfg_data_t'(exp_err));
    check_count("node0 changes", chg0, exp_chg[0]);
    check_count("node1 changes", chg1, exp_chg[1]);
    check_count("node2 changes", chg2, exp_chg[2]);
    check_count("probe mismatches", mis0 + mis1 + mis2, 0);
    if (test_errs == 0) begin
      pass_count++;
      $display("test %0d done: ok", cur_test);
    end else begin
      fail_count++;
      $display("test %0d done: %0d errors", cur_test, test_errs);
    end
  endtask

  initial begin
    int i;
    void'($urandom(32'h244d));
    rst_n          = 1'b0;
    cfg_en         = 1'b0;
    cfg_bit        = 1'b0;
    watchdog_armed = 1'b0;
    pass_count     = 0;
    fail_count     = 0;
    exp0           = cfg_net_pkg::node0_reset;
    exp1           = cfg_net_pkg::node1_reset;
    exp2           = cfg_net_pkg::node2_reset;
    exp_err        = '0;
    exp_chg        = '{0, 0, 0};

    load_tests();
    watchdog_cycles = tnum_q.size() * (cfg_net_pkg::frame_bits * (max_gap + 1) + idle_cycles + 1)
                      + reset_cycles + margin_cycles;
    watchdog_armed  = 1'b1;

    repeat (reset_cycles) @(negedge clk);
    rst_n  = 1'b1;
    cfg_en = 1'b1; // line idles at zero
    repeat (2) @(negedge clk);

    // test 0 is the state right after reset
    cur_test  = 0;
    test_errs = 0;
    check_state();

    for (i = 0; i < tnum_q.size(); i++) begin
      cur_test  = tnum_q[i];
      test_errs = 0;
      update_model(id_q[i], data_q[i], bad_q[i]); // publish before the frame goes out
      send_frame(id_q[i], data_q[i], bad_q[i], gap_q[i]);
      check_state();
    end

    $display("tests passed %0d, tests failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- cfg_node_probe.sv
module cfg_node_probe #(
  parameter int node_num = 0,  // position in the chain
  parameter int width    = 8   // register width of that node
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [width-1:0] data,      // node register under watch
  input  logic [width-1:0] expected,  // value the model published last
  output int               change_count,
  output int               mismatch_count
);

  logic [width-1:0] last_seen;

  // node registers move on the rising edge, so look on the falling one
  always @(negedge clk) begin
    if (!rst_n) begin
      last_seen      <= data; // reset value is the starting point
      change_count   <= 0;
      mismatch_count <= 0;
    end else if (data !== last_seen) begin
      change_count <= change_count + 1;
      assert (data === expected) else begin
        $display("[FAIL] t=%0t node%0d changed to %h, expected %h",
                 $time, node_num, data, expected);
        mismatch_count <= mismatch_count + 1;
      end
      last_seen <= data;
    end
  end

endmodule

//--- cfg_net_top.sv
module cfg_net_top (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                cfg_en,
  input  logic                                cfg_bit,
  output logic [cfg_net_pkg::node0_bits-1:0]  node0_data,
  output logic [cfg_net_pkg::node1_bits-1:0]  node1_data,
  output logic [cfg_net_pkg::node2_bits-1:0]  node2_data,
  output cfg_net_pkg::err_count_t             err_count
);

  // receiver to node 0
  logic                   rx_valid;
  cfg_net_pkg::node_id_t  rx_id;
  cfg_net_pkg::cfg_data_t rx_data;

  // node 0 to node 1
  logic                   hop0_valid;
  cfg_net_pkg::node_id_t  hop0_id;
  cfg_net_pkg::cfg_data_t hop0_data;

  // node 1 to node 2
  logic                   hop1_valid;
  cfg_net_pkg::node_id_t  hop1_id;
  cfg_net_pkg::cfg_data_t hop1_data;

  cfg_frame_rx u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_en    (cfg_en),
    .cfg_bit   (cfg_bit),
    .pkt_valid (rx_valid),
    .pkt_id    (rx_id),
    .pkt_data  (rx_data),
    .err_count (err_count)
  );

  cfg_node #(
    .node_id     (cfg_net_pkg::node0_id),
    .data_bits   (cfg_net_pkg::node0_bits),
    .reset_value (cfg_net_pkg::node0_reset)
  ) u_node0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (rx_valid),
    .in_id     (rx_id),
    .in_data   (rx_data),
    .out_valid (hop0_valid),
    .out_id    (hop0_id),
    .out_data  (hop0_data),
    .data      (node0_data)
  );

  cfg_node #(
    .node_id     (cfg_net_pkg::node1_id),
    .data_bits   (cfg_net_pkg::node1_bits),
    .reset_value (cfg_net_pkg::node1_reset)
  ) u_node1 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (hop0_valid),
    .in_id     (hop0_id),
    .in_data   (hop0_data),
    .out_valid (hop1_valid),
    .out_id    (hop1_id),
    .out_data  (hop1_data),
    .data      (node1_data)
  );

  // end of the chain, nothing listens downstream
  cfg_node #(
    .node_id     (cfg_net_pkg::node2_id),
    .data_bits   (cfg_net_pkg::node2_bits),
    .reset_value (cfg_net_pkg::node2_reset)
  ) u_node2 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (hop1_valid),
    .in_id     (hop1_id),
    .in_data   (hop1_data),
    .out_valid (),
    .out_id    (),
    .out_data  (),
    .data      (node2_data)
  );

endmodule

//--- cfg_node.sv
module cfg_node #(
  parameter cfg_net_pkg::node_id_t node_id     = 8'h00, // own id
  parameter int                    data_bits   = 8,     // width of the local register
  parameter logic [data_bits-1:0]  reset_value = '0
) (
  input  logic                   clk,
  input  logic                   rst_n,

  // packet bus from the upstream stage
  input  logic                   in_valid,
  input  cfg_net_pkg::node_id_t  in_id,
  input  cfg_net_pkg::cfg_data_t in_data,

  // packet bus to the next node, one cycle later
  output logic                   out_valid,
  output cfg_net_pkg::node_id_t  out_id,
  output cfg_net_pkg::cfg_data_t out_data,

  output logic [data_bits-1:0]   data       // configuration register
);

  logic id_match;

  // own id or broadcast
  assign id_match = in_valid &&
                    ((in_id == node_id) || (in_id == cfg_net_pkg::broadcast_id));

  // relay strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  // relay fields, meaningful only with out_valid
  always_ff @(posedge clk) begin
    out_id   <= in_id;
    out_data <= in_data;
  end

  // load on the same edge that relays the strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data <= reset_value;
    end else if (id_match) begin
      data <= in_data[data_bits-1:0]; // keep the low bits only
    end
  end

endmodule

//--- cfg_frame_rx.sv
module cfg_frame_rx (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    cfg_en,    // bits only count while high
  input  logic                    cfg_bit,
  output logic                    pkt_valid,
  output cfg_net_pkg::node_id_t   pkt_id,
  output cfg_net_pkg::cfg_data_t  pkt_data,
  output cfg_net_pkg::err_count_t err_count
);

  cfg_net_pkg::rx_state_t state;

  // counts the bits taken after the start bit, 0 .. frame_bits-2
  logic [$clog2(cfg_net_pkg::frame_bits)-1:0] bit_cnt;

  logic [cfg_net_pkg::payload_bits-1:0] shift_reg; // id then data, MSB first

  logic shifting;   // enabled sample inside a frame
  logic last_bit;   // the parity bit is on the line
  logic frame_done; // parity bit sampled on this edge
  logic parity_ok;

  assign shifting   = cfg_en && (state == cfg_net_pkg::rx_shift);
  assign last_bit   = (bit_cnt == cfg_net_pkg::frame_bits - 2);
  assign frame_done = shifting && last_bit;

  // even parity over id, data and the parity bit itself
  assign parity_ok = ~^{shift_reg, cfg_bit};

  // frame FSM, holds its place while cfg_en is low
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= cfg_net_pkg::rx_idle;
      bit_cnt <= '0;
    end else if (cfg_en) begin
      case (state)
        cfg_net_pkg::rx_idle: begin
          if (cfg_bit) begin // start bit
            state   <= cfg_net_pkg::rx_shift;
            bit_cnt <= '0;
          end
        end
        cfg_net_pkg::rx_shift: begin
          if (last_bit) begin
            state <= cfg_net_pkg::rx_idle; // good or bad, the frame is over
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        default: begin
          state <= cfg_net_pkg::rx_idle;
        end
      endcase
    end
  end

  // payload bits only, parity never enters the shifter
  always_ff @(posedge clk) begin
    if (shifting && !last_bit) begin
      shift_reg <= {shift_reg[cfg_net_pkg::payload_bits-2:0], cfg_bit};
    end
  end

  // one-cycle strobe for a good frame
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pkt_valid <= 1'b0;
    end else begin
      pkt_valid <= frame_done && parity_ok;
    end
  end

  // packet fields, valid only with the strobe
  always_ff @(posedge clk) begin
    if (frame_done && parity_ok) begin
      {pkt_id, pkt_data} <= shift_reg;
    end
  end

  // bad parity drops the frame and bumps the counter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_count <= '0;
    end else if (frame_done && !parity_ok) begin
      err_count <= err_count + 1'b1; // wraps at 256
    end
  end

endmodule

//--- cfg_net_pkg.sv
package cfg_net_pkg;

  // widths that carry a meaning on the packet bus
  typedef logic [7:0]  node_id_t;   // destination id of a packet
  typedef logic [15:0] cfg_data_t;  // packet payload
  typedef logic [7:0]  err_count_t; // bad frame counter, wraps

  // frame layout, sent MSB first on cfg_bit
  //   start(1) | id(8) | data(16) | even parity(1)
  localparam int frame_bits   = 26;
  localparam int payload_bits = $bits(node_id_t) + $bits(cfg_data_t); // id and data

  // every node accepts this id
  localparam node_id_t broadcast_id = 8'hff;

  // node ids along the chain
  localparam node_id_t node0_id = 8'h11;
  localparam node_id_t node1_id = 8'h22;
  localparam node_id_t node2_id = 8'h33;

  // register width kept by each node
  localparam int node0_bits = 16;
  localparam int node1_bits = 8;
  localparam int node2_bits = 4;

  // register contents after reset
  localparam logic [node0_bits-1:0] node0_reset = 16'ha5c3;
  localparam logic [node1_bits-1:0] node1_reset = 8'h3c;
  localparam logic [node2_bits-1:0] node2_reset = 4'h9;

  // receiver FSM
  typedef enum logic {
    rx_idle,  // line idles at zero, waiting for a start bit
    rx_shift  // collecting id, data and parity
  } rx_state_t;

endpackage
